// File: Makefile
# Verilator build and run for the UMI endpoint testbench

VERILATOR ?= verilator
TOP       ?= umi_endpoint_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
SIM       ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
logic/umi_pkg.sv
logic/umi_cmd_decode.sv
logic/umi_endpoint.sv
logic/umi_regfile.sv
logic/umi_endpoint_top.sv
test/umi_endpoint_tb.sv

// File: logic/umi_cmd_decode.sv
//######################################
// UMI command decoder
// Splits a raw command into its fields and
// sorts the opcode into one of four classes
//######################################
module umi_cmd_decode
  (
   input  logic [31:0]        cmd_raw,
   output umi_pkg::umi_cmd_t  cmd,
   output logic               is_read,
   output logic               is_write,
   output logic               is_posted,
   output logic               is_unsupported
   );

   import umi_pkg::*;

   //######################################
   // Unpack
   //######################################
   assign cmd = umi_cmd_t'(cmd_raw);

   //######################################
   // Classify
   //######################################
   assign is_read   = (cmd.opcode == UMI_REQ_READ);
   assign is_write  = (cmd.opcode == UMI_REQ_WRITE);
   assign is_posted = (cmd.opcode == UMI_REQ_WRITE_POSTED);

   // Everything else, atomics and link commands included
   assign is_unsupported = ~(is_read | is_write | is_posted);

   // Endpoint relies on exactly one class per command
   always_comb
   begin
      assert ($onehot({is_read, is_write, is_posted, is_unsupported}))
         else $error("umi_cmd_decode: class flags not one-hot for opcode %0d",
                     cmd.opcode);
   end

endmodule

// File: logic/umi_endpoint.sv
//######################################
// UMI device endpoint
// Accepts requests, drives the local memory
// port and returns read and write responses
// REG=1 adds an output register stage
//######################################
module umi_endpoint
  #(parameter REG = 1)
   (
    input  logic                clk,
    input  logic                nreset,
    // Request port
    input  umi_pkg::umi_req_t   req,
    input  logic                req_valid,
    output logic                req_ready,
    // Response port
    output umi_pkg::umi_resp_t  resp,
    output logic                resp_valid,
    input  logic                resp_ready,
    // Local memory port
    output umi_pkg::umi_addr_t  loc_addr,
    output logic                loc_write,
    output logic                loc_read,
    output umi_pkg::umi_data_t  loc_wrdata,
    input  umi_pkg::umi_data_t  loc_rddata,
    input  logic                loc_ready
    );

   import umi_pkg::*;

   umi_cmd_t  cmd;
   umi_cmd_t  resp_cmd;
   logic      is_read;
   logic      is_write;
   logic      is_posted;
   logic      is_unsupported;
   logic      accept;
   logic      has_resp;
   logic      s1_valid;
   logic      s1_fresh;      // First cycle after accept
   logic      s1_adv;        // Stage 1 hands its response on
   umi_resp_t s1_pkt;
   umi_resp_t s1_out;

   umi_cmd_decode i_umi_cmd_decode
     (.cmd_raw        (req.cmd),
      .cmd            (cmd),
      .is_read        (is_read),
      .is_write       (is_write),
      .is_posted      (is_posted),
      .is_unsupported (is_unsupported));

   //######################################
   // Request side
   //######################################
   assign req_ready = loc_ready & (~s1_valid | s1_adv);
   assign accept    = req_valid & req_ready;
   assign has_resp  = is_read | is_write | is_unsupported;

   assign loc_addr   = req.dstaddr;
   assign loc_wrdata = req.data;
   assign loc_read   = accept & is_read;
   assign loc_write  = accept & (is_write | is_posted);

   // Response command, everything copied except opcode and err
   always_comb
   begin
      resp_cmd        = cmd;
      resp_cmd.opcode = is_read ? UMI_RESP_READ : UMI_RESP_WRITE;
      if (is_unsupported)
         resp_cmd.err = UMI_ERR_UNSUPPORTED;
   end

   //######################################
   // Response stage 1
   //######################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         s1_valid <= 1'b0;
         s1_fresh <= 1'b0;
      end
      else
      begin
         s1_fresh <= accept & has_resp;
         if (accept & has_resp)
            s1_valid <= 1'b1;
         else if (s1_adv)
            s1_valid <= 1'b0;
      end

   // Addresses swapped on the way back
   always_ff @(posedge clk)
      if (accept & has_resp)
      begin
         s1_pkt.cmd     <= resp_cmd;
         s1_pkt.dstaddr <= req.srcaddr;
         s1_pkt.srcaddr <= req.dstaddr;
      end
      else if (s1_fresh)
         s1_pkt.data <= loc_rddata;     // Hold read data under back-pressure

   // Read data comes straight from memory in the first cycle
   always_comb
   begin
      s1_out = s1_pkt;
      if (s1_fresh)
         s1_out.data = loc_rddata;
   end

   //######################################
   // Output stage
   //######################################
   if (REG)
   begin : g_reg
      logic      s2_valid;
      umi_resp_t s2_pkt;

      assign s1_adv = s1_valid & (~s2_valid | resp_ready);

      always_ff @(posedge clk or negedge nreset)
         if (!nreset)
            s2_valid <= 1'b0;
         else if (s1_adv)
            s2_valid <= 1'b1;
         else if (resp_ready)
            s2_valid <= 1'b0;

      always_ff @(posedge clk)
         if (s1_adv)
            s2_pkt <= s1_out;

      assign resp       = s2_pkt;
      assign resp_valid = s2_valid;
   end
   else
   begin : g_direct
      assign s1_adv     = s1_valid & resp_ready;
      assign resp       = s1_out;
      assign resp_valid = s1_valid;
   end

   // A stalled response must not change
   assert property (@(posedge clk) disable iff (!nreset)
                    resp_valid & ~resp_ready |=> resp_valid & $stable(resp))
      else $error("umi_endpoint: resp changed while stalled");

   assert property (@(posedge clk) disable iff (!nreset) !(loc_read & loc_write))
      else $error("umi_endpoint: loc_read and loc_write both high");

endmodule

// File: logic/umi_endpoint_top.sv
//######################################
// UMI endpoint with register file
// Endpoint in front of a small local memory
//######################################
module umi_endpoint_top
  #(parameter REG   = 1,
    parameter DEPTH = 16)
   (
    input  logic                clk,
    input  logic                nreset,
    input  umi_pkg::umi_req_t   req,
    input  logic                req_valid,
    output logic                req_ready,
    output umi_pkg::umi_resp_t  resp,
    output logic                resp_valid,
    input  logic                resp_ready
    );

   import umi_pkg::*;

   // Local memory port
   umi_addr_t loc_addr;
   umi_data_t loc_wrdata;
   umi_data_t loc_rddata;
   logic      loc_write;
   logic      loc_read;
   logic      loc_ready;

   umi_endpoint #(.REG (REG)) i_umi_endpoint
     (.clk        (clk),
      .nreset     (nreset),
      .req        (req),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .resp       (resp),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .loc_addr   (loc_addr),
      .loc_write  (loc_write),
      .loc_read   (loc_read),
      .loc_wrdata (loc_wrdata),
      .loc_rddata (loc_rddata),
      .loc_ready  (loc_ready));

   umi_regfile #(.DEPTH (DEPTH)) i_umi_regfile
     (.clk        (clk),
      .nreset     (nreset),
      .loc_addr   (loc_addr),
      .loc_write  (loc_write),
      .loc_read   (loc_read),
      .loc_wrdata (loc_wrdata),
      .loc_rddata (loc_rddata),
      .loc_ready  (loc_ready));

endmodule

// File: logic/umi_pkg.sv
//######################################
// UMI shared definitions
// Widths, opcodes, the command layout and
// the request and response packets
//######################################
package umi_pkg;

   //######################################
   // Widths
   //######################################
   typedef logic [63:0] umi_addr_t;
   typedef logic [63:0] umi_data_t;
   typedef logic [4:0]  umi_opcode_t;

   //######################################
   // Opcodes
   //######################################
   localparam umi_opcode_t UMI_REQ_READ         = 5'd1;
   localparam umi_opcode_t UMI_REQ_WRITE_POSTED = 5'd3;
   localparam umi_opcode_t UMI_REQ_WRITE        = 5'd5;
   localparam umi_opcode_t UMI_RESP_READ        = 5'd8;
   localparam umi_opcode_t UMI_RESP_WRITE       = 5'd9;

   // Error code returned for opcodes the endpoint does not handle
   localparam logic [1:0] UMI_ERR_UNSUPPORTED = 2'd2;

   // 32 bit command word, msb first
   typedef struct packed {
      logic [4:0]  hostid;
      logic [1:0]  err;
      logic        ex;
      logic        eof;
      logic        eom;
      logic [1:0]  prot;
      logic [3:0]  qos;
      logic [7:0]  len;    // Burst length, not acted on
      logic [2:0]  size;
      umi_opcode_t opcode;
   } umi_cmd_t;

   // Request packet, 224 bits
   typedef struct packed {
      logic [31:0] cmd;    // Raw command word
      umi_addr_t   dstaddr;
      umi_addr_t   srcaddr;
      umi_data_t   data;
   } umi_req_t;

   // Response packet, same layout as the request
   typedef struct packed {
      logic [31:0] cmd;
      umi_addr_t   dstaddr;
      umi_addr_t   srcaddr;
      umi_data_t   data;
   } umi_resp_t;

endpackage

// File: logic/umi_regfile.sv
//######################################
// UMI register file
// Word addressed memory, one cycle read
// latency, one recovery cycle per write
//######################################
module umi_regfile
  #(parameter DEPTH = 16)
   (
    input  logic                clk,
    input  logic                nreset,
    input  umi_pkg::umi_addr_t  loc_addr,
    input  logic                loc_write,
    input  logic                loc_read,
    input  umi_pkg::umi_data_t  loc_wrdata,
    output umi_pkg::umi_data_t  loc_rddata,
    output logic                loc_ready
    );

   import umi_pkg::*;

   localparam int IW = $clog2(DEPTH);

   umi_data_t     mem [DEPTH];
   logic [IW-1:0] index;
   logic          busy;           // Write recovery cycle

   // 64 bit words, so bits 2:0 select a byte; upper bits wrap
   assign index = loc_addr[3 +: IW];

   //######################################
   // Storage
   //######################################
   always_ff @(posedge clk)
      if (loc_write)
         mem[index] <= loc_wrdata;

   // Read data valid the cycle after loc_read
   always_ff @(posedge clk)
      if (loc_read)
         loc_rddata <= mem[index];

   //######################################
   // Ready
   //######################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         busy <= 1'b0;
      else
         busy <= loc_write;

   assign loc_ready = ~busy;

   // Requester has to honour the recovery cycle
   assert property (@(posedge clk) disable iff (!nreset)
                    (loc_read | loc_write) |-> loc_ready)
      else $error("umi_regfile: access while not ready");

endmodule

// File: test/umi_endpoint_tb.sv
//########################################
// UMI endpoint testbench
// Random requests against a reference memory
// with random back-pressure on responses
//########################################
module umi_endpoint_tb;

   import umi_pkg::*;

   localparam int DEPTH      = 16;
   localparam int WAIT_LIMIT = 100;

   logic        clk        = 1'b0;
   logic        resp_ready = 1'b0;
   logic [31:0] bp_rnd     = ~32'd40189;   // Own stream for back-pressure
   logic        nreset;
   umi_req_t    req;
   logic        req_valid;
   logic        req_ready;
   umi_resp_t   resp;
   logic        resp_valid;
   logic        wr_op;
   logic [31:0] rnd;
   umi_data_t   ref_mem [DEPTH];
   umi_resp_t   exp_q [$];               // Expected responses, in order
   logic        rd_q [$];                // Data compared only for reads
   int          n_expected = 0;
   int          n_resp     = 0;
   int          n_resp_err = 0;
   int          n_stall_err = 0;
   int          n_reset_err = 0;
   int          n_recov_err = 0;
   int          n_count_err = 0;
   logic        hung = 1'b0;

   umi_endpoint_top #(.REG (1), .DEPTH (DEPTH)) i_umi_endpoint_top
     (.clk        (clk),
      .nreset     (nreset),
      .req        (req),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .resp       (resp),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready));

   always #4 clk = ~clk;

   assign wr_op = (req.cmd[4:0] == UMI_REQ_WRITE) | (req.cmd[4:0] == UMI_REQ_WRITE_POSTED);

   //########################################
   // Random numbers
   //########################################
   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      rnd = xorshift(rnd);
      return rnd;
   endfunction

   // Kind 0-2 read, 3-4 write, 5 posted, others unsupported
   function automatic logic [31:0] random_cmd(input logic [2:0] kind);
      logic [31:0] r;
      umi_opcode_t op;
      r = next_rand();
      op = r[4:0];
      if (kind <= 3'd2)
         op = UMI_REQ_READ;
      else if (kind <= 3'd4)
         op = UMI_REQ_WRITE;
      else if (kind == 3'd5)
         op = UMI_REQ_WRITE_POSTED;
      else if (op == UMI_REQ_READ || op == UMI_REQ_WRITE || op == UMI_REQ_WRITE_POSTED)
         op = op + 5'd1;                 // Nudge onto an unsupported code
      return {r[31:5], op};
   endfunction

   always @(posedge clk)
   begin
      #1;
      bp_rnd     = xorshift(bp_rnd);
      resp_ready = (bp_rnd[1:0] != 2'b00);   // Stalls about one cycle in four
   end

   //########################################
   // Reference model and scoreboard
   //########################################
   task automatic show_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
      n_resp_err++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
   endtask

   task automatic record_request;
      umi_cmd_t    c;
      umi_resp_t   e;
      logic [63:0] word;
      int          idx;
      c    = umi_cmd_t'(req.cmd);
      word = req.dstaddr >> 3;             // 8 byte words
      idx  = int'(word % 64'(DEPTH));
      e.dstaddr = req.srcaddr;
      e.srcaddr = req.dstaddr;
      e.data    = ref_mem[idx];
      if (c.opcode == UMI_REQ_READ)
         c.opcode = UMI_RESP_READ;
      else if (c.opcode == UMI_REQ_WRITE || c.opcode == UMI_REQ_WRITE_POSTED)
      begin
         ref_mem[idx] = req.data;
         c.opcode     = UMI_RESP_WRITE;
      end
      else
      begin
         c.opcode = UMI_RESP_WRITE;
         c.err    = UMI_ERR_UNSUPPORTED;
      end
      e.cmd = c;
      if (req.cmd[4:0] != UMI_REQ_WRITE_POSTED)
      begin
         exp_q.push_back(e);
         rd_q.push_back(req.cmd[4:0] == UMI_REQ_READ);
         n_expected++;
      end
   endtask

   task automatic check_response;
      umi_resp_t e;
      logic      rd;
      n_resp++;
      if (exp_q.size() == 0)
      begin
         n_resp_err++;
         $display("t=%0t response arrived with no request outstanding", $time);
      end
      else
      begin
         e  = exp_q.pop_front();
         rd = rd_q.pop_front();
         assert (resp.cmd == e.cmd)
            else show_mismatch("resp.cmd", 64'(resp.cmd), 64'(e.cmd));
         assert (resp.dstaddr == e.dstaddr)
            else show_mismatch("resp.dstaddr", resp.dstaddr, e.dstaddr);
         assert (resp.srcaddr == e.srcaddr)
            else show_mismatch("resp.srcaddr", resp.srcaddr, e.srcaddr);
         assert (!rd || resp.data == e.data)
            else show_mismatch("resp.data", resp.data, e.data);
      end
   endtask

   // Handshakes settled by mid-cycle
   always @(negedge clk)
      if (nreset)
      begin
         if (resp_valid && resp_ready)
            check_response();
         if (req_valid && req_ready)
            record_request();
      end

   //########################################
   // Protocol assertions
   //########################################
   assert property (@(posedge clk) !nreset |=> !resp_valid)
      else
      begin
         n_reset_err++;
         $display("FAILED t=%0t resp_valid got 1 expected 0", $time);
      end

   assert property (@(posedge clk) disable iff (!nreset)
                    resp_valid && !resp_ready |=> resp_valid && $stable(resp))
      else
      begin
         n_stall_err++;
         $display("t=%0t response changed or dropped while stalled", $time);
      end

   // Write recovery cycle blocks the next request
   assert property (@(posedge clk) disable iff (!nreset)
                    req_valid && req_ready && wr_op |=> !req_ready)
      else
      begin
         n_recov_err++;
         $display("FAILED t=%0t req_ready got 1 expected 0", $time);
      end

   //########################################
   // Stimulus
   //########################################
   task automatic timeout(input string what);
      hung = 1'b1;
      $display("t=%0t timed out waiting for %s", $time, what);
   endtask

   task automatic send_request(input logic [31:0] cmd, input umi_addr_t dst,
                               input umi_addr_t src, input umi_data_t data);
      int n;
      if (hung)
         return;
      req       = {cmd, dst, src, data};
      req_valid = 1'b1;
      n = 0;
      @(negedge clk);
      while (!req_ready && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (req_ready)
      begin
         @(posedge clk);
         #1;
      end
      else
         timeout("a request to be accepted");
      req_valid = 1'b0;
   endtask

   initial
   begin
      int          i;
      int          n;
      logic [31:0] k;
      umi_addr_t   a;
      umi_addr_t   s;
      umi_data_t   d;
      nreset    = 1'b0;
      req       = '0;
      req_valid = 1'b0;
      rnd       = 32'd40189;
      repeat (3) @(posedge clk);
      #1;
      nreset = 1'b1;
      n = 0;
      @(negedge clk);
      while (!req_ready && n < 2)
      begin
         @(negedge clk);
         n++;
      end
      if (!req_ready)
         timeout("req_ready after reset");
      @(posedge clk);
      #1;
      // Every word written once so reads have known data
      for (i = 0; i < DEPTH; i++)
      begin
         a = ({next_rand(), next_rand()} * 64'(DEPTH) + 64'(i)) << 3;
         s = {next_rand(), next_rand()};
         d = {next_rand(), next_rand()};
         send_request(random_cmd(3'd3), a, s, d);
      end
      // Posted write, then read it back
      a = {next_rand(), next_rand()};
      d = {next_rand(), next_rand()};
      send_request(random_cmd(3'd5), a, s, d);
      send_request(random_cmd(3'd0), a, s, d);
      for (i = 0; i < 300 && !hung; i++)
      begin
         k = next_rand();
         a = {next_rand(), next_rand()};
         s = {next_rand(), next_rand()};
         d = {next_rand(), next_rand()};
         send_request(random_cmd(k[2:0]), a, s, d);
         if (k[5:4] == 2'b00)
         begin
            repeat (int'(k[7:6]) + 1) @(posedge clk);
            #1;
         end
      end
      n = 0;
      while (exp_q.size() != 0 && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0)
         timeout("all responses to return");
      repeat (10) @(negedge clk);          // Room for a stray response
      if (n_resp != n_expected)
      begin
         n_count_err++;
         $display("FAILED t=%0t response count got %0d expected %0d",
                  $time, n_resp, n_expected);
      end
      $display("errors resp %0d stall %0d reset %0d recovery %0d count %0d timeout %0d",
               n_resp_err, n_stall_err, n_reset_err, n_recov_err, n_count_err, hung);
      if (n_resp_err + n_stall_err + n_reset_err + n_recov_err + n_count_err == 0 && !hung)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule
